/* source/seg_display_params.svh */
// seg_display parameters
// digit count, scan slot length and slots per digit for the multiplexed display

`ifndef SEG_DISPLAY_PARAMS_SVH
`define SEG_DISPLAY_PARAMS_SVH

// number of display digits, least significant is digit 0
`define SEG_DIGITS 4

// CLK cycles per scan slot, the last one is always dark
`define SEG_SLOT_CYCLES 8

// slots per digit: segments a to g, then dp
`define SEG_SLOTS 8

`endif

/* source/seg_display_pkg.sv */
// seg_display shared types
// digit, segment, anode and count vectors plus the scanner state enum

`include "seg_display_params.svh"

package seg_display_pkg;

	typedef logic [3:0] bcd_t; // one hex or bcd digit
	typedef logic [6:0] seg_t; // active low, bit 6 = a ... bit 0 = g
	typedef logic [`SEG_DIGITS-1:0] anode_t; // one-hot digit enable, active high
	typedef logic [4*`SEG_DIGITS-1:0] count_t; // packed digits, msd first

	typedef enum logic {
		idle, // after reset, nothing shown yet
		scan // cycling through slots
	} scan_state_t;

endpackage

/* source/digit_if.sv */
// digit_if
// one display digit: value and blank/dp flags from the counter, segment pattern from the decoder

`timescale 1ns/100ps

interface digit_if;
	import seg_display_pkg::*;

	bcd_t digit; // digit value
	logic blank; // leading zero, show nothing
	logic dp; // decimal point request
	seg_t pattern; // decoded active-low segments

	modport counter (
		output digit, blank, dp
	);

	modport decoder (
		input digit, blank,
		output pattern
	);

	modport scanner (
		input pattern, dp
	);
endinterface

/* source/bcd_counter.sv */
// bcd_counter
// four-digit decimal counter with step and load strobes, drives each digit and its blank flag

`timescale 1ns/100ps
`include "seg_display_params.svh"

module bcd_counter (
	input logic CLK,
	input logic reset,
	input logic step, // one-cycle +1 strobe
	input logic load, // one-cycle load strobe, beats step
	input seg_display_pkg::count_t load_value,
	input logic [`SEG_DIGITS-1:0] dp_sel,
	output seg_display_pkg::count_t count_value,
	digit_if.counter digits [`SEG_DIGITS-1:0]
);
	import seg_display_pkg::*;

	count_t cnt; // digit k lives at [4*k +: 4]
	logic [`SEG_DIGITS-1:0] carry; // increment request into each digit
	logic [`SEG_DIGITS-1:0] at_nine; // digit is about to roll over
	logic [`SEG_DIGITS-1:0] blank_v; // leading-zero flags

	// ripple carry, step enters at the lsd
	always_comb begin
		for (int k = 0; k < `SEG_DIGITS; k++) begin
			at_nine[k] = (cnt[4*k +: 4] == 4'd9);
		end
		carry[0] = step;
		for (int k = 1; k < `SEG_DIGITS; k++) begin
			carry[k] = carry[k-1] && at_nine[k-1]; // previous digit wraps
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= load_value; // load wins over step
		end else begin
			for (int k = 0; k < `SEG_DIGITS; k++) begin
				if (carry[k]) begin
					cnt[4*k +: 4] <= at_nine[k] ? 4'd0 : cnt[4*k +: 4] + 4'd1; // 9999 -> 0000
				end
			end
		end
	end

	// blank a digit when it and everything above it is zero
	// digit 0 always shows, so a zero count reads as a single 0
	always_comb begin
		blank_v = '0;
		blank_v[`SEG_DIGITS-1] = (cnt[4*(`SEG_DIGITS-1) +: 4] == 4'd0);
		for (int k = `SEG_DIGITS-2; k > 0; k--) begin
			blank_v[k] = blank_v[k+1] && (cnt[4*k +: 4] == 4'd0);
		end
	end

	assign count_value = cnt;

	for (genvar i = 0; i < `SEG_DIGITS; i++) begin : g_digit
		assign digits[i].digit = cnt[4*i +: 4];
		assign digits[i].blank = blank_v[i];
		assign digits[i].dp = dp_sel[i]; // level straight from the pins
	end
endmodule

/* source/digit_decoder.sv */
// digit_decoder
// hex to active-low seven-segment decode, all segments off when the digit is blanked

`timescale 1ns/100ps

module digit_decoder (
	digit_if.decoder dig
);
	import seg_display_pkg::*;

	seg_t code; // abcdefg, 0 = lit

	always_comb begin
		case (dig.digit)
			4'h0 : code = 7'b0000001;
			4'h1 : code = 7'b1001111;
			4'h2 : code = 7'b0010010;
			4'h3 : code = 7'b0000110;
			4'h4 : code = 7'b1001100;
			4'h5 : code = 7'b0100100;
			4'h6 : code = 7'b0100000;
			4'h7 : code = 7'b0001111;
			4'h8 : code = 7'b0000000;
			4'h9 : code = 7'b0000100;
			4'ha : code = 7'b0001000; // A
			4'hb : code = 7'b1100000; // lower case b
			4'hc : code = 7'b0110001; // C
			4'hd : code = 7'b1000010; // lower case d
			4'he : code = 7'b0110000; // E
			default : code = 7'b0111000; // F
		endcase
	end

	assign dig.pattern = dig.blank ? '1 : code; // blanked digit stays dark
endmodule

/* source/segment_scanner.sv */
// segment_scanner
// lights one segment at a time: digit 0 first, slots a..g then dp, last cycle of each slot dark

`timescale 1ns/100ps
`include "seg_display_params.svh"

module segment_scanner (
	input logic CLK,
	input logic reset,
	digit_if.scanner digits [`SEG_DIGITS-1:0],
	output seg_display_pkg::anode_t anode,
	output seg_display_pkg::seg_t segment_n,
	output logic dp_n
);
	import seg_display_pkg::*;

	localparam int CYC_W = $clog2(`SEG_SLOT_CYCLES);
	localparam int SLOT_W = $clog2(`SEG_SLOTS);
	localparam int DIG_W = $clog2(`SEG_DIGITS);
	localparam int SEG_TOP = $bits(seg_t) - 1; // bit of segment a

	localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(`SEG_SLOT_CYCLES - 1); // dark cycle
	localparam logic [SLOT_W-1:0] SLOT_DP = SLOT_W'(`SEG_SLOTS - 1);
	localparam logic [DIG_W-1:0] DIG_LAST = DIG_W'(`SEG_DIGITS - 1);

	scan_state_t state;
	logic [CYC_W-1:0] cyc, next_cyc; // cycle within slot
	logic [SLOT_W-1:0] slot, next_slot; // segment slot within digit
	logic [DIG_W-1:0] dig, next_dig; // digit being shown
	seg_t pat [`SEG_DIGITS]; // decoder patterns, indexable
	logic [`SEG_DIGITS-1:0] dp_v; // dp requests
	anode_t anode_d;
	seg_t seg_d;
	logic dp_d;

	for (genvar i = 0; i < `SEG_DIGITS; i++) begin : g_gather
		assign pat[i] = digits[i].pattern;
		assign dp_v[i] = digits[i].dp;
	end

	// position shown after this edge; idle shows slot 0 of digit 0 first
	always_comb begin
		next_cyc = cyc;
		next_slot = slot;
		next_dig = dig;
		if (state == scan) begin
			if (cyc == CYC_LAST) begin
				next_cyc = '0;
				if (slot == SLOT_DP) begin
					next_slot = '0;
					next_dig = (dig == DIG_LAST) ? '0 : dig + 1'b1; // lsd after msd
				end else begin
					next_slot = slot + 1'b1;
				end
			end else begin
				next_cyc = cyc + 1'b1;
			end
		end
	end

	// output pattern for the next position
	always_comb begin
		anode_d = '0;
		seg_d = '1;
		dp_d = 1'b1;
		if (next_cyc != CYC_LAST) begin // dark cycle keeps everything off
			anode_d = anode_t'(1) << next_dig;
			if (next_slot == SLOT_DP) begin
				dp_d = ~dp_v[next_dig];
			end else begin
				seg_d[SEG_TOP - next_slot] = pat[next_dig][SEG_TOP - next_slot]; // own segment only
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= idle;
			cyc <= '0;
			slot <= '0;
			dig <= '0;
			anode <= '0;
			segment_n <= '1;
			dp_n <= 1'b1;
		end else begin
			state <= scan;
			cyc <= next_cyc;
			slot <= next_slot;
			dig <= next_dig;
			anode <= anode_d;
			segment_n <= seg_d;
			dp_n <= dp_d;
		end
	end
endmodule

/* source/seg_display.sv */
// seg_display
// four-digit multiplexed seven-segment controller: counter, per-digit decoders, segment scanner

`timescale 1ns/100ps
`include "seg_display_params.svh"

module seg_display (
	input logic CLK,
	input logic reset,
	input logic step, // one-cycle count strobe
	input logic load, // one-cycle load strobe
	input seg_display_pkg::count_t load_value, // bcd, msd first
	input logic [`SEG_DIGITS-1:0] dp_sel, // decimal point per digit
	output seg_display_pkg::count_t count_value,
	output seg_display_pkg::anode_t anode, // one-hot, active high
	output seg_display_pkg::seg_t segment_n, // abcdefg, active low
	output logic dp_n
);

	digit_if digits [`SEG_DIGITS-1:0] (); // one bundle per digit

	bcd_counter u_bcd_counter (
		.CLK (CLK),
		.reset (reset),
		.step (step),
		.load (load),
		.load_value (load_value),
		.dp_sel (dp_sel),
		.count_value (count_value),
		.digits (digits)
	);

	for (genvar i = 0; i < `SEG_DIGITS; i++) begin : g_dec
		digit_decoder u_digit_decoder (
			.dig (digits[i])
		);
	end

	segment_scanner u_segment_scanner (
		.CLK (CLK),
		.reset (reset),
		.digits (digits),
		.anode (anode),
		.segment_n (segment_n),
		.dp_n (dp_n)
	);
endmodule

/* verif/seg_display_assertions.sv */
// seg_display_assertions
// scanner pin rules: anode zero or one-hot, one lit output at most, nothing lit while dark

`timescale 1ns/100ps

module seg_display_assertions (
	input logic CLK,
	input logic reset,
	input seg_display_pkg::anode_t anode,
	input seg_display_pkg::seg_t segment_n,
	input logic dp_n
);
	import seg_display_pkg::*;

	logic [$bits(seg_t):0] low_n; // segment lines plus dp, active low

	assign low_n = {segment_n, dp_n};

	a_anode_onehot : assert property (@(posedge CLK) disable iff (reset) $onehot0(anode))
		else $error("anode not zero or one-hot: %b", anode);

	// one segment per slot keeps the drive current low
	a_single_low : assert property (@(posedge CLK) disable iff (reset) $countones(~low_n) <= 1)
		else $error("more than one segment line low: %b", low_n);

	a_dark_off : assert property (@(posedge CLK) disable iff (reset) (anode == '0) |-> (low_n == '1))
		else $error("segment line low while no digit selected: %b", low_n);
endmodule

bind segment_scanner seg_display_assertions u_seg_display_assertions (
	.CLK (CLK),
	.reset (reset),
	.anode (anode),
	.segment_n (segment_n),
	.dp_n (dp_n)
);

/* verif/seg_display_tb.sv */
// seg_display testbench
// applies a table of count operations and checks a full scan frame after each one

`timescale 1ns/100ps
`include "seg_display_params.svh"

module seg_display_tb;
	import seg_display_pkg::*;

	localparam int FRAME = `SEG_DIGITS * `SEG_SLOTS * `SEG_SLOT_CYCLES; // cycles per full scan
	localparam int OP_STEP = 0;
	localparam int OP_LOAD = 1;
	localparam int OP_BOTH = 2; // load and step in the same cycle
	localparam int OP_HOLD = 3; // dp_sel change without a strobe
	localparam int WAIT_LIMIT = 16; // cycles before a wait gives up

	logic CLK;
	logic reset;
	logic step;
	logic load;
	count_t load_value;
	logic [`SEG_DIGITS-1:0] dp_sel;
	count_t count_value;
	anode_t anode;
	seg_t segment_n;
	logic dp_n;

	int errors; // check errors from the test sequence
	int monitor_errors; // pin rule errors seen on any cycle
	int passed;
	int failed;
	bit timed_out;
	bit monitor_on;

	int op_q [$];
	count_t val_q [$];
	logic [`SEG_DIGITS-1:0] dp_q [$];
	int reps_q [$]; // strobes per row
	count_t exp_q [$];
	string name_q [$];
	int lit_cnt [`SEG_DIGITS][`SEG_SLOTS]; // cycles each digit/slot was seen lit

	seg_display u_seg_display (
		.CLK (CLK),
		.reset (reset),
		.step (step),
		.load (load),
		.load_value (load_value),
		.dp_sel (dp_sel),
		.count_value (count_value),
		.anode (anode),
		.segment_n (segment_n),
		.dp_n (dp_n)
	);

	always #2 CLK = ~CLK; // 4 ns period

	task automatic tick();
		@(posedge CLK);
		#1; // inputs change just after the edge
	endtask

	// lit segments of a digit as abcdefg with 1 for on
	function automatic logic [6:0] lit_segments(bcd_t d);
		case (d)
			4'h0 : return 7'b1111110;
			4'h1 : return 7'b0110000;
			4'h2 : return 7'b1101101;
			4'h3 : return 7'b1111001;
			4'h4 : return 7'b0110011;
			4'h5 : return 7'b1011011;
			4'h6 : return 7'b1011111;
			4'h7 : return 7'b1110000;
			4'h8 : return 7'b1111111;
			4'h9 : return 7'b1111011;
			4'ha : return 7'b1110111; // A
			4'hb : return 7'b0011111; // b
			4'hc : return 7'b1001110; // C
			4'hd : return 7'b0111101; // d
			4'he : return 7'b1001111; // E
			default : return 7'b1000111; // F
		endcase
	endfunction

	// leading zero when this digit and all above it are zero and it is not digit 0
	function automatic bit is_blank(count_t c, int k);
		bit z;
		z = (k != 0);
		for (int j = k; j < `SEG_DIGITS; j++) begin
			if (c[4*j +: 4] != 4'd0) begin
				z = 1'b0;
			end
		end
		return z;
	endfunction

	task automatic add_row(input string name, input int op, input count_t val,
			input logic [`SEG_DIGITS-1:0] dp, input int reps, input count_t exp);
		name_q.push_back(name);
		op_q.push_back(op);
		val_q.push_back(val);
		dp_q.push_back(dp);
		reps_q.push_back(reps);
		exp_q.push_back(exp);
	endtask

	task automatic build_table();
		add_row("step from zero", OP_STEP, 16'h0000, 4'b0000, 1, 16'h0001);
		add_row("load 0009", OP_LOAD, 16'h0009, 4'b0000, 1, 16'h0009);
		add_row("carry 0009 to 0010", OP_STEP, 16'h0000, 4'b0000, 1, 16'h0010);
		add_row("load 0099", OP_LOAD, 16'h0099, 4'b0000, 1, 16'h0099);
		add_row("carry 0099 to 0100", OP_STEP, 16'h0000, 4'b0000, 1, 16'h0100);
		add_row("load 0995", OP_LOAD, 16'h0995, 4'b0000, 1, 16'h0995);
		add_row("seven steps to 1002", OP_STEP, 16'h0000, 4'b0000, 7, 16'h1002);
		add_row("load 9999", OP_LOAD, 16'h9999, 4'b0000, 1, 16'h9999);
		add_row("wrap 9999 to 0000", OP_STEP, 16'h0000, 4'b0000, 1, 16'h0000);
		add_row("load 0042", OP_LOAD, 16'h0042, 4'b0000, 1, 16'h0042);
		add_row("load beats step", OP_BOTH, 16'h1234, 4'b0000, 1, 16'h1234);
		add_row("dp on digits 0 and 2", OP_HOLD, 16'h0000, 4'b0101, 1, 16'h1234);
		add_row("hex letters, dp on digit 3", OP_LOAD, 16'h00af, 4'b1000, 1, 16'h00af);
		add_row("load 8888, all dps", OP_LOAD, 16'h8888, 4'b1111, 1, 16'h8888);
	endtask

	// pulse the strobes of one row and wait for the new count
	task automatic apply_row(input int i, output int errs);
		int n;
		errs = 0;
		dp_sel = dp_q[i];
		load_value = val_q[i];
		for (int r = 0; r < reps_q[i]; r++) begin
			step = (op_q[i] == OP_STEP) || (op_q[i] == OP_BOTH);
			load = (op_q[i] == OP_LOAD) || (op_q[i] == OP_BOTH);
			tick();
			step = 1'b0;
			load = 1'b0;
			if (r < reps_q[i] - 1) begin
				tick(); // gap between strobes
			end
		end
		n = 1; // one edge since the last strobe
		while (count_value !== exp_q[i] && n <= WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (n > WAIT_LIMIT) begin
			$display("timeout: count_value stuck at %h, expected %h", count_value, exp_q[i]);
			timed_out = 1'b1;
		end else if (n != 1) begin
			$display("error at %0t: count %h after %0d cycles, expected 1", $time, count_value, n);
			errs++;
		end
	endtask

	// watch the pins for one frame and rebuild what each digit showed
	task automatic check_frame(input int i, output int errs);
		count_t c;
		logic [6:0] lit;
		int want;
		bit on;
		errs = 0;
		c = exp_q[i];
		for (int d = 0; d < `SEG_DIGITS; d++) begin
			for (int s = 0; s < `SEG_SLOTS; s++) begin
				lit_cnt[d][s] = 0;
			end
		end
		tick();
		tick(); // new patterns reach the output registers
		for (int t = 0; t < FRAME; t++) begin
			tick(); // registered outputs settled after the edge
			for (int d = 0; d < `SEG_DIGITS; d++) begin
				if (anode == anode_t'(1 << d)) begin
					for (int s = 0; s < `SEG_SLOTS - 1; s++) begin
						if (segment_n[6 - s] == 1'b0) begin
							lit_cnt[d][s]++;
						end
					end
					if (dp_n == 1'b0) begin
						lit_cnt[d][`SEG_SLOTS-1]++;
					end
				end
			end
		end
		for (int d = 0; d < `SEG_DIGITS; d++) begin
			lit = is_blank(c, d) ? 7'b0 : lit_segments(c[4*d +: 4]);
			for (int s = 0; s < `SEG_SLOTS; s++) begin
				on = (s == `SEG_SLOTS - 1) ? dp_q[i][d] : lit[6 - s];
				want = on ? `SEG_SLOT_CYCLES - 1 : 0; // last cycle of a slot is dark
				if (lit_cnt[d][s] != want) begin
					$display("error at %0t: digit %0d slot %0d lit %0d cycles, expected %0d",
						$time, d, s, lit_cnt[d][s], want);
					errs++;
				end
			end
		end
	endtask

	task automatic wait_scan_start(inout int errs);
		int n;
		n = 0;
		while (anode == '0 && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (anode == '0) begin
			$display("timeout: scanner never selected a digit after reset");
			timed_out = 1'b1;
		end else if (n != 1 || anode !== anode_t'(1)) begin
			$display("error at %0t: first slot after %0d cycles on anode %b, expected 1 on digit 0",
				$time, n, anode);
			errs++;
		end
	endtask

	task automatic report_test(input string name, input int errs, input int mon);
		errors += errs;
		if (errs == 0 && mon == 0 && !timed_out) begin
			passed++;
			$display("test %s: pass", name);
		end else begin
			failed++;
			$display("test %s: fail (%0d errors)", name, errs + mon);
		end
	endtask

	// pin rules that hold on every cycle out of reset
	always @(negedge CLK) begin
		if (monitor_on) begin
			if (!$onehot0(anode)) begin
				$display("error at %0t: anode %b not zero or one-hot", $time, anode);
				monitor_errors++;
			end
			if ($countones({~segment_n, ~dp_n}) > 1) begin
				$display("error at %0t: several lines low %b %b", $time, segment_n, dp_n);
				monitor_errors++;
			end
			if (anode == '0 && (segment_n != '1 || dp_n != 1'b1)) begin
				$display("error at %0t: line low while dark %b %b", $time, segment_n, dp_n);
				monitor_errors++;
			end
		end
	end

	initial begin
		int errs;
		int frame_errs;
		int mon_before;
		CLK = 1'b0;
		reset = 1'b1;
		step = 1'b0;
		load = 1'b0;
		load_value = '0;
		dp_sel = '0;
		errors = 0;
		monitor_errors = 0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		monitor_on = 1'b0;
		build_table();
		repeat (5) tick(); // reset over 5 edges
		reset = 1'b0;
		errs = 0;
		if (anode !== '0 || segment_n !== '1 || dp_n !== 1'b1 || count_value !== '0) begin
			$display("error at %0t: after reset anode=%b segment_n=%b dp_n=%b count=%h",
				$time, anode, segment_n, dp_n, count_value);
			errs++;
		end
		monitor_on = 1'b1;
		wait_scan_start(errs);
		report_test("reset", errs, 0);
		for (int i = 0; i < name_q.size(); i++) begin
			if (timed_out) begin
				break;
			end
			mon_before = monitor_errors;
			apply_row(i, errs);
			if (!timed_out) begin
				check_frame(i, frame_errs);
				errs += frame_errs;
			end
			report_test(name_q[i], errs, monitor_errors - mon_before);
		end
		$display("tests: %0d passed, %0d failed, %0d errors", passed, failed,
			errors + monitor_errors);
		if (errors == 0 && monitor_errors == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end
endmodule

/* seg_display.f */
+incdir+source
source/seg_display_pkg.sv
source/digit_if.sv
source/bcd_counter.sv
source/digit_decoder.sv
source/segment_scanner.sv
source/seg_display.sv
verif/seg_display_assertions.sv
verif/seg_display_tb.sv

/* Makefile */
# seg_display simulation and lint with Verilator

TOP = seg_display_tb

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f seg_display.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f seg_display.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
